// ==== dv/tb_angle_to_pwm.sv ====
// Testbench for the angle to PWM controller
// Runs near-target requests, full moves and an aborted move against a motor model
// A separate process checks every PWM ratio against the expected profile phase
`timescale 1ns/1ps
`default_nettype none

`include "angle_pwm_config.svh"

module tb_angle_to_pwm;

    localparam int PH_ACCEL  = 0;
    localparam int PH_CRUISE = 1;
    localparam int PH_DECEL  = 2;
    localparam int RAMP [16] = '{4, 12, 19, 26, 33, 40, 45, 51, 56, 61, 66, 70, 74, 77, 80, 82};

    logic                       clock;
    logic                       reset_n;
    angle_pwm_pkg::angle_t      target_angle;
    angle_pwm_pkg::angle_t      current_angle;
    logic                       pwm_done;
    logic                       angle_update;
    logic                       abort_angle;
    angle_pwm_pkg::motion_cfg_t cfg;
    angle_pwm_pkg::pwm_cmd_t    cmd;
    logic                       angle_done;

    logic [15:0] lfsr;
    int          done_count;      // angle_done pulses seen
    int          moves_done;
    int          k;               // Ramp index tracked from cmd.ratio
    int          phase;
    logic        reached_cruise;
    logic        abort_seen;

    angle_to_pwm i_dut (.*);
    tb_motor_model i_motor (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        repeat (count) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // Returns {direction, distance} along the shorter way round the wheel
    function automatic logic [12:0] shortest_path(input angle_pwm_pkg::angle_t target,
                                                  input angle_pwm_pkg::angle_t current);
        int diff;
        diff = (int'(target) - int'(current) + 4096) % 4096;
        if (diff < 2048)
            return {1'b1, 12'(diff)};
        else
            return {1'b0, 12'(4096 - diff)};
    endfunction

    function automatic int profile_value(input int idx, input int offset);
        return (RAMP[idx] + offset) % 256;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $fatal(1, "Timeout");
    endtask

    always @(negedge clock) begin : compare_ratio
        int          expected;
        logic [12:0] path;
        if (reset_n) begin
            if (angle_done)
                done_count = done_count + 1;
            if (!cmd.update) begin
                phase = PH_ACCEL;
                k     = -1;
            end else if (cmd.ratio != '0) begin
                if (abort_seen && phase == PH_ACCEL)
                    phase = PH_DECEL;               // Ramp turns back from the current step
                case (phase)
                    PH_ACCEL: begin
                        if (k < 15 && cmd.ratio == profile_value(k + 1, cfg.profile_offset))
                            k = k + 1;
                        else if (k == 15 && cmd.ratio != profile_value(15, cfg.profile_offset)) begin
                            phase          = PH_CRUISE;
                            reached_cruise = 1'b1;
                        end
                    end
                    PH_CRUISE: begin
                        if (cmd.ratio != cfg.cruise_power) begin
                            phase = PH_DECEL;
                            path  = shortest_path(target_angle, current_angle);
                            // Every move here is big, and the encoder steps one count at a time
                            check_value("decel_threshold", `DECEL_BIG - 1, path[11:0]);
                        end
                    end
                    default: begin
                        if (k > 0 && cmd.ratio == profile_value(k - 1, cfg.profile_offset))
                            k = k - 1;
                    end
                endcase
                if (k < 0)
                    k = 0;                          // First ratio must be the table start
                expected = (phase == PH_CRUISE) ? cfg.cruise_power :
                           profile_value(k, cfg.profile_offset);
                check_value("profile_ratio", expected, cmd.ratio);
            end
        end
    end

    task automatic issue_request(input angle_pwm_pkg::angle_t target,
                                 input angle_pwm_pkg::motion_cfg_t new_cfg);
        @(posedge clock);
        target_angle   <= target;
        cfg            <= new_cfg;
        angle_update   <= 1'b1;
        abort_seen     = 1'b0;
        reached_cruise = 1'b0;
        @(posedge clock);
        angle_update <= 1'b0;
    endtask

    task automatic run_near_request();
        int                    offset;
        int                    sign_bit;
        angle_pwm_pkg::angle_t target;
        random_bits(3, offset);
        random_bits(1, sign_bit);
        offset = offset % (`TARGET_TOL + 1);
        target = sign_bit ? current_angle + 12'(offset) : current_angle - 12'(offset);
        issue_request(target, cfg);
        repeat (20) begin
            @(negedge clock);
            check_value("near_ratio", 0, cmd.ratio);
            check_value("near_update", 0, cmd.update);
            check_value("near_done", 0, angle_done);
        end
    endtask

    task automatic run_move(input logic with_abort);
        int                         value;
        int                         sign_bit;
        int                         cycles;
        angle_pwm_pkg::angle_t      target;
        angle_pwm_pkg::motion_cfg_t new_cfg;
        logic [12:0]                path;
        random_bits(1, value);
        new_cfg.delay_target = 8'(value);
        random_bits(6, value);
        new_cfg.profile_offset = 8'(value);
        random_bits(6, value);
        new_cfg.cruise_power = 8'(160 + value);     // Kept above every ramp entry
        random_bits(9, value);
        value = value + 300;
        random_bits(1, sign_bit);
        target = sign_bit ? current_angle + 12'(value) : current_angle - 12'(value);
        path = shortest_path(target, current_angle);
        issue_request(target, new_cfg);

        cycles = 0;
        while (!cmd.update && cycles < 50) begin
            @(negedge clock);
            cycles++;
        end
        if (!cmd.update)
            report_timeout("the move to start");
        check_value("move_direction", path[12], cmd.direction);

        if (with_abort) begin
            cycles = 0;
            while (k < 3 && cycles < 5000) begin
                @(posedge clock);
                cycles++;
            end
            if (k < 3)
                report_timeout("the ramp to reach step 3");
            abort_angle <= 1'b1;
            abort_seen  = 1'b1;
            @(posedge clock);
            abort_angle <= 1'b0;
        end

        cycles = 0;
        while (!angle_done && cycles < 20000) begin
            @(negedge clock);
            cycles++;
        end
        if (!angle_done)
            report_timeout("angle_done");
        path = shortest_path(target, current_angle);
        check_value("done_in_tolerance", 1, path[11:0] < `TARGET_TOL);
        if (!with_abort)
            check_value("reached_cruise", 1, reached_cruise);
        moves_done++;
        repeat (10) @(negedge clock);
        check_value("done_pulses", moves_done, done_count);
        check_value("ratio_after_done", 0, cmd.ratio);
    endtask

    initial begin
        reset_n        = 1'b0;
        target_angle   = '0;
        angle_update   = 1'b0;
        abort_angle    = 1'b0;
        cfg            = '0;
        lfsr           = 16'd22981;
        done_count     = 0;
        moves_done     = 0;
        k              = -1;
        phase          = PH_ACCEL;
        reached_cruise = 1'b0;
        abort_seen     = 1'b0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        @(negedge clock);
        check_value("reset_done", 0, angle_done);
        check_value("reset_update", 0, cmd.update);
        check_value("reset_ratio", 0, cmd.ratio);
        check_value("reset_direction", 0, cmd.direction);

        repeat (3) run_near_request();
        repeat (3) run_move(1'b0);
        run_move(1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_motor_model.sv ====
// Behavioral PWM and encoder for the angle to PWM testbench
// Acknowledges a PWM period every 8 clocks and steps the angle while the ratio is nonzero
`timescale 1ns/1ps
`default_nettype none

module tb_motor_model (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire angle_pwm_pkg::pwm_cmd_t cmd,
    output logic                         pwm_done,
    output angle_pwm_pkg::angle_t        current_angle
);

    localparam angle_pwm_pkg::angle_t START_ANGLE = 12'd1000;

    logic [2:0] period_cnt;   // Clocks within one PWM period

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            period_cnt    <= '0;
            pwm_done      <= 1'b0;
            current_angle <= START_ANGLE;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            pwm_done   <= (period_cnt == 3'd7);   // High for one clock per period

            // Encoder moves one count per powered period
            if (period_cnt == 3'd7 && cmd.ratio != '0) begin
                if (cmd.direction)
                    current_angle <= current_angle + 1'b1;
                else
                    current_angle <= current_angle - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== include/angle_pwm_config.svh ====
// Build-time constants for the angle to PWM controller
// Included by the package and by RTL that needs widths, tolerances or thresholds
`ifndef ANGLE_PWM_CONFIG_SVH
`define ANGLE_PWM_CONFIG_SVH

// Datapath widths
`define ANGLE_W        12                      // 4096 counts per turn
`define RATIO_W        8                       // PWM high time out of 255
`define STEP_W         4
`define PROFILE_DEPTH  (1 << `STEP_W)          // Entries in the ramp table

// Dwell per profile step, counted in acknowledged PWM periods
`define DELAY_W        8
`define DELAY_SHIFT    4
`define DWELL_W        (`DELAY_W + `DELAY_SHIFT)

// Stop window around the target
`define TARGET_TOL     5

// Size class boundaries on the initial distance
`define SMALL_LIMIT    30
`define MED_LIMIT      50

// Remaining distance at which cruise hands over to deceleration
`define DECEL_SMALL    5
`define DECEL_MED      8
`define DECEL_BIG      10

`endif

// ==== src.f ====
+incdir+include
verilog/angle_pwm_pkg.sv
verilog/angle_delta.sv
verilog/step_pacer.sv
verilog/motion_sequencer.sv
verilog/angle_to_pwm.sv
dv/tb_motor_model.sv
dv/tb_angle_to_pwm.sv

// ==== verilog/angle_delta.sv ====
// Shortest-path distance and direction from the encoder angle to the target
// Sampled every clock while calc_enable is high, one cycle of latency
`timescale 1ns/1ps
`default_nettype none

`include "angle_pwm_config.svh"

module angle_delta (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         calc_enable,
    input  wire angle_pwm_pkg::angle_t  target_angle,
    input  wire angle_pwm_pkg::angle_t  current_angle,
    output angle_pwm_pkg::delta_info_t  delta_info
);

    localparam angle_pwm_pkg::angle_t HALF_TURN = angle_pwm_pkg::angle_t'(1 << (`ANGLE_W - 1));

    angle_pwm_pkg::angle_t diff;
    logic                  ahead;

    // Subtraction wraps modulo one turn
    assign diff  = target_angle - current_angle;
    assign ahead = (diff < HALF_TURN);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            delta_info <= '0;
        end else if (calc_enable) begin
            delta_info.delta        <= ahead ? diff : -diff;   // Going backwards is 4096 - diff
            delta_info.dir_shortest <= ahead;
            delta_info.valid        <= 1'b1;
        end else begin
            delta_info.valid <= 1'b0;
        end
    end

    // Shortest path never exceeds half a turn
    a_delta_half_turn: assert property (
        @(posedge clock) disable iff (!reset_n)
        delta_info.valid |-> (delta_info.delta <= HALF_TURN)
    );

endmodule

`default_nettype wire

// ==== verilog/angle_pwm_pkg.sv ====
// Shared types for the angle to PWM controller
// RTL and testbench refer to these by scoped name
`default_nettype none

`include "angle_pwm_config.svh"

package angle_pwm_pkg;

    typedef logic [`ANGLE_W-1:0] angle_t;   // Position on the wheel
    typedef logic [`RATIO_W-1:0] ratio_t;

    // Move phases
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        CALC     = 3'd1,
        ACCEL    = 3'd2,
        CRUISE   = 3'd3,
        DECEL    = 3'd4,
        SHUTDOWN = 3'd5
    } motion_state_e;

    // Picks the deceleration threshold for a move
    typedef enum logic [1:0] {
        SMALL  = 2'd0,
        MEDIUM = 2'd1,
        BIG    = 2'd2
    } size_class_e;

    typedef struct packed {
        logic [`DELAY_W-1:0] delay_target;     // PWM periods per step, before the shift
        ratio_t              profile_offset;   // Added to every ramp table entry
        ratio_t              cruise_power;
    } motion_cfg_t;

    typedef struct packed {
        angle_t delta;          // Shortest distance to the target
        logic   dir_shortest;   // 1 when the target is ahead
        logic   valid;
    } delta_info_t;

    typedef struct packed {
        logic   update;
        ratio_t ratio;
        logic   direction;
    } pwm_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/angle_to_pwm.sv ====
// Top level of the angle to PWM controller
// Joins the distance calculator, the step pacer and the move FSM
`timescale 1ns/1ps
`default_nettype none

module angle_to_pwm (
    input  wire                             clock,
    input  wire                             reset_n,
    input  wire angle_pwm_pkg::angle_t      target_angle,
    input  wire angle_pwm_pkg::angle_t      current_angle,   // From the motor encoder
    input  wire                             pwm_done,
    input  wire                             angle_update,
    input  wire                             abort_angle,
    input  wire angle_pwm_pkg::motion_cfg_t cfg,
    output angle_pwm_pkg::pwm_cmd_t         cmd,
    output logic                            angle_done
);

    angle_pwm_pkg::delta_info_t delta_info;
    logic                       calc_enable;
    logic                       pace_run;
    logic                       step_tick;

    angle_delta u_angle_delta (
        .clock          (clock),
        .reset_n        (reset_n),
        .calc_enable    (calc_enable),
        .target_angle   (target_angle),
        .current_angle  (current_angle),
        .delta_info     (delta_info)
    );

    step_pacer u_step_pacer (
        .clock          (clock),
        .reset_n        (reset_n),
        .pace_run       (pace_run),
        .pwm_done       (pwm_done),
        .delay_target   (cfg.delay_target),
        .step_tick      (step_tick)
    );

    motion_sequencer u_motion_sequencer (
        .clock          (clock),
        .reset_n        (reset_n),
        .angle_update   (angle_update),
        .abort_angle    (abort_angle),
        .pwm_done       (pwm_done),
        .cfg            (cfg),
        .delta_info     (delta_info),
        .step_tick      (step_tick),
        .calc_enable    (calc_enable),
        .pace_run       (pace_run),
        .cmd            (cmd),
        .angle_done     (angle_done)
    );

endmodule

`default_nettype wire

// ==== verilog/motion_sequencer.sv ====
// Move FSM for the angle to PWM controller
// Runs calc, accel, cruise, decel and shutdown, and drives the PWM command
// Distance comes from angle_delta, step timing from step_pacer
`timescale 1ns/1ps
`default_nettype none

`include "angle_pwm_config.svh"

module motion_sequencer (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         angle_update,
    input  wire                         abort_angle,
    input  wire                         pwm_done,
    input  wire angle_pwm_pkg::motion_cfg_t cfg,
    input  wire angle_pwm_pkg::delta_info_t delta_info,
    input  wire                         step_tick,
    output logic                        calc_enable,
    output logic                        pace_run,
    output angle_pwm_pkg::pwm_cmd_t     cmd,
    output logic                        angle_done
);

    localparam logic [`STEP_W-1:0] STEP_LAST = '1;

    // Linear ramp, offset by cfg.profile_offset
    localparam angle_pwm_pkg::ratio_t LINEAR_PROFILE [`PROFILE_DEPTH] = '{
        8'd4,  8'd12, 8'd19, 8'd26, 8'd33, 8'd40, 8'd45, 8'd51,
        8'd56, 8'd61, 8'd66, 8'd70, 8'd74, 8'd77, 8'd80, 8'd82
    };

    angle_pwm_pkg::motion_state_e state;
    angle_pwm_pkg::motion_state_e next_state;
    angle_pwm_pkg::size_class_e   size_class;
    angle_pwm_pkg::ratio_t        profile_ratio;
    angle_pwm_pkg::angle_t        decel_limit;
    logic [`STEP_W-1:0]           step;
    logic                         in_tol;    // Inside the stop window

    assign profile_ratio = LINEAR_PROFILE[step] + cfg.profile_offset;   // Wraps at 8 bits
    assign in_tol        = delta_info.delta < angle_pwm_pkg::angle_t'(`TARGET_TOL);

    // Distance stays tracked for the whole move
    assign calc_enable = (state != angle_pwm_pkg::IDLE);
    assign pace_run    = (state == angle_pwm_pkg::ACCEL) || (state == angle_pwm_pkg::CRUISE) ||
                         (state == angle_pwm_pkg::DECEL);

    always_comb begin
        case (size_class)
            angle_pwm_pkg::SMALL:  decel_limit = angle_pwm_pkg::angle_t'(`DECEL_SMALL);
            angle_pwm_pkg::MEDIUM: decel_limit = angle_pwm_pkg::angle_t'(`DECEL_MED);
            default:               decel_limit = angle_pwm_pkg::angle_t'(`DECEL_BIG);
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            angle_pwm_pkg::IDLE: begin
                if (angle_update)
                    next_state = angle_pwm_pkg::CALC;
            end
            angle_pwm_pkg::CALC: begin
                if (abort_angle)
                    next_state = angle_pwm_pkg::IDLE;
                else if (delta_info.valid)
                    next_state = (delta_info.delta > angle_pwm_pkg::angle_t'(`TARGET_TOL)) ?
                                 angle_pwm_pkg::ACCEL : angle_pwm_pkg::IDLE;
            end
            angle_pwm_pkg::ACCEL: begin
                if (abort_angle)
                    next_state = angle_pwm_pkg::DECEL;
                else if (step == STEP_LAST)
                    next_state = angle_pwm_pkg::CRUISE;
            end
            angle_pwm_pkg::CRUISE: begin
                if (abort_angle || (delta_info.valid && delta_info.delta < decel_limit))
                    next_state = angle_pwm_pkg::DECEL;
            end
            angle_pwm_pkg::DECEL: begin
                if (delta_info.valid && in_tol)
                    next_state = angle_pwm_pkg::SHUTDOWN;
            end
            angle_pwm_pkg::SHUTDOWN: begin
                if (pwm_done)                        // Let the PWM finish its period
                    next_state = angle_pwm_pkg::IDLE;
            end
            default: next_state = angle_pwm_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= angle_pwm_pkg::IDLE;
            size_class <= angle_pwm_pkg::SMALL;
            step       <= '0;
            cmd        <= '0;
            angle_done <= 1'b0;
        end else begin
            state      <= next_state;
            angle_done <= (state == angle_pwm_pkg::SHUTDOWN) && (next_state == angle_pwm_pkg::IDLE);

            case (state)
                angle_pwm_pkg::CALC: begin
                    step      <= '0;
                    cmd.ratio <= '0;
                    if (next_state == angle_pwm_pkg::ACCEL) begin
                        // Move starts here
                        cmd.update    <= 1'b1;
                        cmd.direction <= delta_info.dir_shortest;
                        if (delta_info.delta < angle_pwm_pkg::angle_t'(`SMALL_LIMIT))
                            size_class <= angle_pwm_pkg::SMALL;
                        else if (delta_info.delta < angle_pwm_pkg::angle_t'(`MED_LIMIT))
                            size_class <= angle_pwm_pkg::MEDIUM;
                        else
                            size_class <= angle_pwm_pkg::BIG;
                    end
                end
                angle_pwm_pkg::ACCEL: begin
                    cmd.ratio <= profile_ratio;
                    if (step_tick && step != STEP_LAST)
                        step <= step + 1'b1;
                end
                angle_pwm_pkg::CRUISE: begin
                    cmd.ratio <= cfg.cruise_power;
                end
                angle_pwm_pkg::DECEL: begin
                    cmd.ratio <= profile_ratio;
                    if (step_tick && step != '0)     // Hold at the bottom of the ramp
                        step <= step - 1'b1;
                end
                default: begin
                    cmd.ratio <= '0;                 // Idle and shutdown
                end
            endcase

            if (next_state == angle_pwm_pkg::IDLE)
                cmd.update <= 1'b0;
        end
    end

    // Done only follows shutdown, with the motor already off
    a_done_after_shutdown: assert property (
        @(posedge clock) disable iff (!reset_n)
        angle_done |-> ($past(state) == angle_pwm_pkg::SHUTDOWN) && (cmd.ratio == '0) &&
                       !cmd.update
    );

endmodule

`default_nettype wire

// ==== verilog/step_pacer.sv ====
// Paces the motion profile on acknowledged PWM periods
// Pulses step_tick once every (delay_target << DELAY_SHIFT) + 1 pwm_done rises
`timescale 1ns/1ps
`default_nettype none

`include "angle_pwm_config.svh"

module step_pacer (
    input  wire                 clock,
    input  wire                 reset_n,
    input  wire                 pace_run,
    input  wire                 pwm_done,
    input  wire [`DELAY_W-1:0]  delay_target,
    output logic                step_tick
);

    logic                 pwm_done_q;
    logic                 ack;
    logic [`DWELL_W-1:0]  dwell_cnt;
    logic [`DWELL_W-1:0]  dwell_target;

    assign dwell_target = {delay_target, {`DELAY_SHIFT{1'b0}}};

    // A period counts only once the PWM has dropped and raised done again
    assign ack = pwm_done & ~pwm_done_q;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pwm_done_q <= 1'b0;
            dwell_cnt  <= '0;
            step_tick  <= 1'b0;
        end else begin
            pwm_done_q <= pwm_done;
            step_tick  <= 1'b0;

            if (!pace_run) begin
                dwell_cnt <= '0;            // Fresh count for every move
            end else if (ack) begin
                if (dwell_cnt == dwell_target) begin
                    dwell_cnt <= '0;
                    step_tick <= 1'b1;
                end else begin
                    dwell_cnt <= dwell_cnt + 1'b1;
                end
            end
        end
    end

    // Each tick needs a fresh acknowledgment
    a_tick_single: assert property (
        @(posedge clock) disable iff (!reset_n)
        step_tick |=> !step_tick
    );

endmodule

`default_nettype wire
